/* bus68020Pkg.sv */
package bus68020Pkg;

    typedef logic [31:0] addrT;
    typedef logic [31:0] dataT;

    typedef logic [1:0] sizeT;             // 00 means four bytes

    localparam sizeT Siz1 = 2'b01;
    localparam sizeT Siz2 = 2'b10;
    localparam sizeT Siz3 = 2'b11;
    localparam sizeT Siz4 = 2'b00;

    typedef logic [1:0] laneT;             // Lane 0 is bits 31:24
    typedef logic [2:0] byteCountT;        // 0 to 4 bytes

    // Slave answer, active low
    typedef enum logic [1:0] {
        Dsack32   = 2'b00,
        Dsack16   = 2'b01,
        Dsack8    = 2'b10,
        DsackWait = 2'b11
    } dsackT;

    typedef enum logic [2:0] {
        ResetWait,
        Idle,
        Addr,
        Data,
        Term
    } busStateT;

endpackage

/* busController.sv */
`timescale 1ns/1ps

module busController #(
    parameter int ResetDelay = 4
) (
    input  logic                   CLK,
    input  logic                   in_RESET,
    input  logic                   start,
    input  logic                   startWrite,
    input  bus68020Pkg::addrT      startAddr,
    input  bus68020Pkg::sizeT      startSize,
    input  bus68020Pkg::dsackT     dsack,
    input  bus68020Pkg::byteCountT taken,
    input  logic                   lastCycle,
    output logic                   busy,
    output logic                   done,
    output bus68020Pkg::addrT      busAddr,
    output bus68020Pkg::sizeT      busSiz,
    output logic                   busRnw,
    output logic                   busAs,
    output logic                   busDs,
    output logic                   dataOutEn,
    output logic                   latch
);

    localparam int CntW = (ResetDelay > 1) ? $clog2(ResetDelay + 1) : 1;

    bus68020Pkg::busStateT  state;
    logic [CntW-1:0]        delayCnt;
    bus68020Pkg::byteCountT takenQ;        // Step of the cycle just acknowledged
    logic                   lastQ;

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            state    <= bus68020Pkg::ResetWait;
            delayCnt <= CntW'(ResetDelay);
            done     <= 1'b0;
            busRnw   <= 1'b1;
        end else begin
            done <= 1'b0;
            case (state)
                bus68020Pkg::ResetWait: begin
                    if (delayCnt <= 1) begin
                        state <= bus68020Pkg::Idle;
                    end else begin
                        delayCnt <= delayCnt - 1'b1;
                    end
                end
                bus68020Pkg::Idle: begin
                    if (start) begin
                        busAddr <= startAddr;
                        busSiz  <= startSize;
                        busRnw  <= !startWrite;
                        state   <= bus68020Pkg::Addr;
                    end
                end
                bus68020Pkg::Addr: begin
                    state <= bus68020Pkg::Data;
                end
                bus68020Pkg::Data: begin
                    if (dsack != bus68020Pkg::DsackWait) begin
                        takenQ <= taken;
                        lastQ  <= lastCycle;
                        state  <= bus68020Pkg::Term;
                    end
                end
                bus68020Pkg::Term: begin
                    if (lastQ) begin
                        done  <= 1'b1;
                        state <= bus68020Pkg::Idle;
                    end else begin
                        busAddr <= busAddr + bus68020Pkg::addrT'(takenQ);
                        // Two-bit wrap gives 00 for four remaining
                        busSiz  <= busSiz - bus68020Pkg::sizeT'(takenQ);
                        state   <= bus68020Pkg::Addr;
                    end
                end
                default: begin
                    state <= bus68020Pkg::ResetWait;
                end
            endcase
        end
    end

    assign busy      = (state != bus68020Pkg::Idle);
    assign busAs     = !(state == bus68020Pkg::Addr || state == bus68020Pkg::Data);
    assign busDs     = (state != bus68020Pkg::Data);
    assign dataOutEn = (state == bus68020Pkg::Data) && !busRnw;
    assign latch     = (state == bus68020Pkg::Data) && (dsack != bus68020Pkg::DsackWait);

endmodule

/* transferStep.sv */
`timescale 1ns/1ps

module transferStep (
    input  bus68020Pkg::addrT      busAddr,
    input  bus68020Pkg::sizeT      busSiz,
    input  bus68020Pkg::dsackT     dsack,
    output bus68020Pkg::byteCountT taken,
    output bus68020Pkg::laneT      firstLane,
    output logic                   lastCycle
);

    bus68020Pkg::byteCountT remaining;
    bus68020Pkg::byteCountT portBytes;
    bus68020Pkg::byteCountT avail;

    always_comb begin
        remaining = (busSiz == bus68020Pkg::Siz4) ? 3'd4 : {1'b0, busSiz};
        case (dsack)
            bus68020Pkg::Dsack16: begin
                portBytes = 3'd2;
                firstLane = {1'b0, busAddr[0]};   // Lanes 0 and 1
            end
            bus68020Pkg::Dsack8: begin
                portBytes = 3'd1;
                firstLane = 2'd0;
            end
            default: begin
                portBytes = 3'd4;
                firstLane = busAddr[1:0];
            end
        endcase
        // Offset within the port equals the first lane
        avail     = portBytes - {1'b0, firstLane};
        taken     = (remaining < avail) ? remaining : avail;
        lastCycle = (taken == remaining);
    end

endmodule

/* readMerge.sv */
`timescale 1ns/1ps

module readMerge (
    input  logic                   CLK,
    input  logic                   in_RESET,
    input  logic                   start,
    input  logic                   latch,
    input  bus68020Pkg::dataT      dataIn,
    input  bus68020Pkg::laneT      firstLane,
    input  bus68020Pkg::byteCountT taken,
    output bus68020Pkg::dataT      readData
);

    bus68020Pkg::dataT laneAligned;
    bus68020Pkg::dataT newBytes;

    always_comb begin
        laneAligned = dataIn << (8 * firstLane);        // First lane to the top
        newBytes    = laneAligned >> (8 * (4 - taken)); // Right-justify taken bytes
    end

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            readData <= '0;
        end else if (start) begin
            readData <= '0;
        end else if (latch) begin
            readData <= (readData << (8 * taken)) | newBytes;
        end
    end

endmodule

/* writeReplicator.sv */
`timescale 1ns/1ps

module writeReplicator (
    input  logic              CLK,
    input  logic              in_RESET,
    input  logic              start,
    input  bus68020Pkg::dataT writeData,
    input  bus68020Pkg::addrT busAddr,
    input  bus68020Pkg::sizeT busSiz,
    output bus68020Pkg::dataT dataOut
);

    bus68020Pkg::dataT operand;
    logic [7:0]        op3, op2, op1, op0;     // op3 is the most significant

    always_ff @(posedge CLK) begin
        if (!in_RESET) begin
            operand <= '0;
        end else if (start) begin
            operand <= writeData;
        end
    end

    assign {op3, op2, op1, op0} = operand;

    // Remaining bytes are the low busSiz bytes, copied for narrow ports
    always_comb begin
        case (busSiz)
            bus68020Pkg::Siz1: begin
                dataOut = {op0, op0, op0, op0};
            end
            bus68020Pkg::Siz2: begin
                if (!busAddr[0]) begin
                    dataOut = {op1, op0, op1, op0};
                end else begin
                    dataOut = {op1, op1, op0, op1};
                end
            end
            bus68020Pkg::Siz3: begin
                case (busAddr[1:0])
                    2'b00:   dataOut = {op2, op1, op0, op3};
                    2'b01:   dataOut = {op2, op2, op1, op0};
                    2'b10:   dataOut = {op2, op1, op2, op1};
                    default: dataOut = {op2, op2, op1, op2};
                endcase
            end
            default: begin
                case (busAddr[1:0])
                    2'b00:   dataOut = {op3, op2, op1, op0};
                    2'b01:   dataOut = {op3, op3, op2, op1};
                    2'b10:   dataOut = {op3, op2, op3, op2};
                    default: dataOut = {op3, op3, op2, op3};
                endcase
            end
        endcase
    end

endmodule

/* bus68020.sv */
`timescale 1ns/1ps

module bus68020 #(
    parameter int ResetDelay = 4
) (
    input  logic               CLK,
    input  logic               in_RESET,
    input  logic               start,
    input  logic               startWrite,
    input  bus68020Pkg::addrT  startAddr,
    input  bus68020Pkg::sizeT  startSize,
    input  bus68020Pkg::dataT  writeData,
    output logic               busy,
    output logic               done,
    output bus68020Pkg::dataT  readData,
    output bus68020Pkg::addrT  busAddr,
    output bus68020Pkg::sizeT  busSiz,
    output logic               busRnw,
    output logic               busAs,
    output logic               busDs,
    output bus68020Pkg::dataT  dataOut,
    output logic               dataOutEn,
    input  bus68020Pkg::dataT  dataIn,
    input  bus68020Pkg::dsackT dsack
);

    bus68020Pkg::byteCountT taken;
    bus68020Pkg::laneT      firstLane;
    logic                   lastCycle;
    logic                   latch;

    busController #(
        .ResetDelay(ResetDelay)
    ) controller (
        .CLK       (CLK),
        .in_RESET  (in_RESET),
        .start     (start),
        .startWrite(startWrite),
        .startAddr (startAddr),
        .startSize (startSize),
        .dsack     (dsack),
        .taken     (taken),
        .lastCycle (lastCycle),
        .busy      (busy),
        .done      (done),
        .busAddr   (busAddr),
        .busSiz    (busSiz),
        .busRnw    (busRnw),
        .busAs     (busAs),
        .busDs     (busDs),
        .dataOutEn (dataOutEn),
        .latch     (latch)
    );

    transferStep step (
        .busAddr  (busAddr),
        .busSiz   (busSiz),
        .dsack    (dsack),
        .taken    (taken),
        .firstLane(firstLane),
        .lastCycle(lastCycle)
    );

    // Only an accepted start touches the data path
    readMerge merge (
        .CLK      (CLK),
        .in_RESET (in_RESET),
        .start    (start && !busy),
        .latch    (latch),
        .dataIn   (dataIn),
        .firstLane(firstLane),
        .taken    (taken),
        .readData (readData)
    );

    writeReplicator replicator (
        .CLK      (CLK),
        .in_RESET (in_RESET),
        .start    (start && !busy),
        .writeData(writeData),
        .busAddr  (busAddr),
        .busSiz   (busSiz),
        .dataOut  (dataOut)
    );

endmodule

/* tbBusSlave.sv */
`timescale 1ns/1ps

module tbBusSlave (
    input  logic               CLK,
    input  bus68020Pkg::addrT  busAddr,
    input  bus68020Pkg::sizeT  busSiz,
    input  logic               busRnw,
    input  logic               busDs,
    input  bus68020Pkg::dataT  dataOut,
    input  logic [1:0]         waitCycles,
    output bus68020Pkg::dataT  dataIn,
    output bus68020Pkg::dsackT dsack
);

    logic [7:0] mem [0:255];               // Indexed by the low address byte
    logic [1:0] waitCnt;
    int         port;
    int         offset;
    int         count;
    logic [7:0] base;                      // Byte that sits on lane 0

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] <= 8'(i * 29 + 83);
        end
        waitCnt <= 2'd0;
        dataIn  <= '0;
        dsack   <= bus68020Pkg::DsackWait;
    end

    always @(posedge CLK) begin
        if (busDs) begin
            dsack   <= bus68020Pkg::DsackWait;     // Released once the strobe rises
            waitCnt <= 2'd0;
        end else if (dsack == bus68020Pkg::DsackWait && waitCnt < waitCycles) begin
            waitCnt <= waitCnt + 2'd1;
        end else if (dsack == bus68020Pkg::DsackWait) begin
            port   = busAddr[31] ? 1 : (busAddr[30] ? 2 : 4);
            offset = int'(busAddr[1:0]) % port;
            count  = (busSiz == bus68020Pkg::Siz4) ? 4 : int'(busSiz);
            if (count > port - offset) begin
                count = port - offset;
            end
            base = busAddr[7:0] - 8'(offset);
            for (int l = 0; l < 4; l++) begin
                // Lanes outside the port carry junk
                dataIn[31 - 8 * l -: 8] <= (l < port) ? mem[8'(base + l)] : 8'hee;
                if (!busRnw && l >= offset && l < offset + count) begin
                    mem[8'(base + l)] <= dataOut[31 - 8 * l -: 8];
                end
            end
            case (port)
                1:       dsack <= bus68020Pkg::Dsack8;
                2:       dsack <= bus68020Pkg::Dsack16;
                default: dsack <= bus68020Pkg::Dsack32;
            endcase
        end
    end

endmodule

/* tbBus68020.sv */
`timescale 1ns/1ps

module tbBus68020;

    localparam int ResetDelay = 4;
    localparam int ClkPeriod  = 4;
    localparam int NumOps     = 96;            // 3 regions, 4 sizes, 4 offsets, both directions
    localparam int LimitNs    = (NumOps * 4 * (3 + 3) + NumOps * 16 + 200) * ClkPeriod;

    logic               CLK, in_RESET, start, startWrite;
    logic               busy, done, busRnw, busAs, busDs, dataOutEn;
    bus68020Pkg::addrT  startAddr, busAddr;
    bus68020Pkg::sizeT  startSize, busSiz;
    bus68020Pkg::dataT  writeData, readData, dataOut, dataIn;
    bus68020Pkg::dsackT dsack;
    logic [1:0]         waitCycles;
    logic               resetCheck;
    logic               opWrite;               // Direction of the running operation
    logic [31:0]        rng;
    logic [7:0]         shadow [0:255];        // Reference copy of the slave memory
    bus68020Pkg::addrT  expAddr [$];
    bus68020Pkg::sizeT  expSiz [$];
    int                 addrSeen;

    bus68020 #(.ResetDelay(ResetDelay)) dut (.*);
    tbBusSlave slave (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] seen);
        $display("Fail at %0t ns: %s expected %h, seen %h", $time, name, expected, seen);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic reportProblem(input string what);
        $display("Fail at %0t ns: %s", $time, what);
        $display("Checks failed");
        $fatal(1);
    endtask

    // Model the bus cycles and bytes, run the operation, check at done
    task automatic runOp(input logic write, input bus68020Pkg::addrT addr, input int size);
        bus68020Pkg::addrT a;
        bus68020Pkg::dataT wdata;
        bus68020Pkg::dataT expected;
        int                port;
        int                rem;
        int                n;
        int                cycles;
        rng      = xorshift(rng);
        wdata    = rng;
        expected = '0;
        port     = addr[31] ? 1 : (addr[30] ? 2 : 4);
        a        = addr;
        rem      = size;
        while (rem > 0) begin
            n = port - int'(a[1:0]) % port;
            n = (n < rem) ? n : rem;
            expAddr.push_back(a);
            expSiz.push_back(bus68020Pkg::sizeT'(rem));
            a   = a + bus68020Pkg::addrT'(n);
            rem = rem - n;
        end
        cycles = expAddr.size();
        for (int k = 0; k < size; k++) begin
            expected = (expected << 8) | shadow[8'(addr[7:0] + k)];
            if (write) begin
                shadow[8'(addr[7:0] + k)] = wdata[8 * (size - 1 - k) +: 8];
            end
        end
        addrSeen = 0;
        opWrite  = write;
        @(posedge CLK);
        start      <= 1'b1;
        startWrite <= write;
        startAddr  <= addr;
        startSize  <= bus68020Pkg::sizeT'(size);
        writeData  <= wdata;
        waitCycles <= rng[9:8];
        @(posedge CLK);
        start <= 1'b0;
        @(negedge CLK);
        while (dsack == bus68020Pkg::DsackWait) begin
            @(negedge CLK);
        end
        @(posedge CLK);
        rng        = xorshift(rng);
        start      <= 1'b1;                    // Unit is busy here
        startWrite <= rng[0];
        startAddr  <= rng;
        startSize  <= rng[5:4];
        writeData  <= ~rng;
        @(posedge CLK);
        start <= 1'b0;
        @(negedge CLK);
        while (!done) begin
            @(negedge CLK);
        end
        assert (addrSeen == cycles) else reportMismatch("busAs cycle count", cycles, addrSeen);
        if (write) begin
            for (int i = 0; i < 256; i++) begin
                assert (slave.mem[i] === shadow[i])
                    else reportMismatch($sformatf("slave.mem[%0d]", i), shadow[i], slave.mem[i]);
            end
        end else begin
            assert (readData === expected) else reportMismatch("readData", expected, readData);
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #(ClkPeriod / 2) CLK = ~CLK;
    end

    initial begin
        #(LimitNs);
        reportProblem("timeout, the operations did not finish in time");
    end

    assert property (@(posedge CLK)
                     resetCheck |-> {busAs, busDs, dataOutEn, busy, done} == 5'b11010)
        else reportMismatch("{busAs, busDs, dataOutEn, busy, done}", 5'b11010,
                            $sampled({busAs, busDs, dataOutEn, busy, done}));
    assert property (@(posedge CLK) disable iff (!in_RESET)
                     (!busDs && dsack == bus68020Pkg::DsackWait) |=> !busDs)
        else reportProblem("busDs rose while dsack still signalled DsackWait");
    assert property (@(posedge CLK) disable iff (!in_RESET) dataOutEn == (!busDs && opWrite))
        else reportMismatch("dataOutEn", !$sampled(busDs) && $sampled(opWrite),
                            $sampled(dataOutEn));
    assert property (@(posedge CLK) disable iff (!in_RESET) !busAs |-> busRnw == !opWrite)
        else reportMismatch("busRnw", !$sampled(opWrite), $sampled(busRnw));

    // Addr state shows as busAs low with busDs still high
    always @(negedge CLK) begin
        if (!busAs && busDs) begin
            addrSeen++;
            if (expAddr.size() == 0) begin
                reportProblem("address strobe beyond the expected bus cycles");
            end else begin
                assert (busAddr == expAddr[0]) else reportMismatch("busAddr", expAddr[0], busAddr);
                assert (busSiz == expSiz[0]) else reportMismatch("busSiz", expSiz[0], busSiz);
                void'(expAddr.pop_front());
                void'(expSiz.pop_front());
            end
        end
    end

    initial begin
        rng        = 32'h73d5_b833;
        opWrite    = 1'b0;
        in_RESET   <= 1'b0;
        start      <= 1'b0;
        startWrite <= 1'b0;
        startAddr  <= '0;
        startSize  <= bus68020Pkg::Siz1;
        writeData  <= '0;
        waitCycles <= 2'd0;
        resetCheck <= 1'b0;
        @(posedge CLK);
        resetCheck <= 1'b1;
        repeat (9) @(posedge CLK);
        in_RESET <= 1'b1;                      // After ten cycles
        repeat (ResetDelay) @(posedge CLK);
        resetCheck <= 1'b0;
        @(negedge CLK);
        assert (!busy) else reportMismatch("busy", 0, busy);
        for (int i = 0; i < 256; i++) begin
            shadow[i] = slave.mem[i];
        end
        for (int region = 0; region < 3; region++) begin
            for (int size = 1; size <= 4; size++) begin
                for (int offset = 0; offset < 4; offset++) begin
                    rng = xorshift(rng);
                    runOp(1'b0, {2'(region), 1'b0, rng[28:2], 2'(offset)}, size);
                    rng = xorshift(rng);
                    runOp(1'b1, {2'(region), 1'b0, rng[28:2], 2'(offset)}, size);
                end
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

/* sources.f */
bus68020Pkg.sv
busController.sv
transferStep.sv
readMerge.sv
writeReplicator.sv
bus68020.sv
tbBusSlave.sv
tbBus68020.sv

/* Bender.yml */
package:
  name: bus68020

sources:
  - bus68020Pkg.sv
  - busController.sv
  - transferStep.sv
  - readMerge.sv
  - writeReplicator.sv
  - bus68020.sv
  - target: simulation
    files:
      - tbBusSlave.sv
      - tbBus68020.sv
